/* hdl/exe_pkg.sv */
package exe_pkg;

    localparam int data_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int imm_w      = 16;

    // data_req.size encodings
    localparam logic [1:0] size_byte = 2'd0;
    localparam logic [1:0] size_half = 2'd1;
    localparam logic [1:0] size_word = 2'd2;

    typedef enum logic [4:0] {
        op_add, op_addu, op_sub, op_subu, op_slt, op_sltu,
        op_and, op_or, op_xor, op_nor, op_sll, op_srl, op_sra, op_lui,
        op_mult, op_multu, op_mfhi, op_mflo, op_mthi, op_mtlo
    } exe_op_e;

    typedef enum logic [3:0] {
        mem_none, mem_lw, mem_lh, mem_lhu, mem_lb, mem_lbu, mem_sw, mem_sh, mem_sb
    } mem_op_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu, alu_and, alu_or,
        alu_xor, alu_nor, alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

    typedef enum logic [2:0] {
        hilo_none, hilo_mult, hilo_multu, hilo_mthi, hilo_mtlo
    } hilo_op_e;

    typedef enum logic [1:0] {
        res_alu, res_hi, res_lo
    } res_sel_e;

    typedef enum logic [4:0] {
        exc_none = 5'd0,
        exc_adel = 5'd4,
        exc_ades = 5'd5,
        exc_ov   = 5'd12
    } exc_code_e;

    typedef struct packed {
        exe_op_e               op;
        mem_op_e               mem_op;
        logic                  src1_is_sa;
        logic                  src2_is_imm;
        logic                  imm_zero_ext;
        logic                  gr_we;
        logic [reg_addr_w-1:0] dest;
        logic [imm_w-1:0]      imm;
        logic [data_w-1:0]     rs_value;
        logic [data_w-1:0]     rt_value;
        logic [data_w-1:0]     pc;
    } ds_to_es_t;

    typedef struct packed {
        alu_op_e               alu_op;
        logic                  check_ov;
        mem_op_e               mem_op;
        hilo_op_e              hilo_op;
        res_sel_e              res_sel;
        logic                  gr_we;
        logic [reg_addr_w-1:0] dest;
    } exe_ctrl_t;

    typedef struct packed {
        logic [data_w-1:0]     pc;
        logic [data_w-1:0]     result;
        logic [reg_addr_w-1:0] dest;
        logic                  gr_we;
        logic                  is_load;
        exc_code_e             exc_code;
        logic [data_w-1:0]     badvaddr;
    } es_to_ms_t;

    typedef struct packed {
        logic              en;
        logic              wr;
        logic [1:0]        size;
        logic [3:0]        wstrb;
        logic [data_w-1:0] addr;
        logic [data_w-1:0] wdata;
    } mem_req_t;

endpackage

/* hdl/exe_decode.sv */
module exe_decode import exe_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      in_valid,
    input  ds_to_es_t in_inst,
    input  logic      ms_allowin,
    input  logic      ready_go,
    output logic      es_valid,
    output logic      es_allowin,
    output ds_to_es_t inst,
    output exe_ctrl_t ctrl
);

    assign es_allowin = !es_valid || (ready_go && ms_allowin);

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= in_valid;
        end
    end

    // pipeline register, loads only when an instruction enters
    always_ff @(posedge clk) begin
        if (in_valid && es_allowin) begin
            inst <= in_inst;
        end
    end

    always_comb begin
        ctrl.alu_op   = alu_add;
        ctrl.check_ov = 1'b0;
        ctrl.mem_op   = inst.mem_op;
        ctrl.hilo_op  = hilo_none;
        ctrl.res_sel  = res_alu;
        ctrl.gr_we    = inst.gr_we;
        ctrl.dest     = inst.dest;

        case (inst.op)
            op_add: begin
                ctrl.alu_op   = alu_add;
                ctrl.check_ov = 1'b1;
            end
            op_addu:  ctrl.alu_op = alu_add;
            op_sub: begin
                ctrl.alu_op   = alu_sub;
                ctrl.check_ov = 1'b1;
            end
            op_subu:  ctrl.alu_op = alu_sub;
            op_slt:   ctrl.alu_op = alu_slt;
            op_sltu:  ctrl.alu_op = alu_sltu;
            op_and:   ctrl.alu_op = alu_and;
            op_or:    ctrl.alu_op = alu_or;
            op_xor:   ctrl.alu_op = alu_xor;
            op_nor:   ctrl.alu_op = alu_nor;
            op_sll:   ctrl.alu_op = alu_sll;
            op_srl:   ctrl.alu_op = alu_srl;
            op_sra:   ctrl.alu_op = alu_sra;
            op_lui:   ctrl.alu_op = alu_lui;
            op_mult:  ctrl.hilo_op = hilo_mult;
            op_multu: ctrl.hilo_op = hilo_multu;
            op_mthi:  ctrl.hilo_op = hilo_mthi;
            op_mtlo:  ctrl.hilo_op = hilo_mtlo;
            op_mfhi:  ctrl.res_sel = res_hi;
            op_mflo:  ctrl.res_sel = res_lo;
            default:  ctrl.alu_op = alu_add;
        endcase

        // address generation is a plain add, never traps
        if (inst.mem_op != mem_none) begin
            ctrl.alu_op   = alu_add;
            ctrl.check_ov = 1'b0;
        end
    end

endmodule

/* hdl/exe_alu.sv */
module exe_alu import exe_pkg::*; (
    input  ds_to_es_t         inst,
    input  exe_ctrl_t         ctrl,
    output logic [data_w-1:0] alu_result,
    output logic              overflow
);

    logic [data_w-1:0] src1;
    logic [data_w-1:0] src2;
    logic [data_w-1:0] imm_ext;
    logic [data_w-1:0] sum;
    logic [data_w-1:0] diff;
    logic [4:0]        shamt;
    logic              add_ov;
    logic              sub_ov;

    // sa sits in imm[10:6]
    assign src1 = inst.src1_is_sa ? {{(data_w-5){1'b0}}, inst.imm[10:6]} : inst.rs_value;

    assign imm_ext = inst.imm_zero_ext ? {{(data_w-imm_w){1'b0}}, inst.imm}
                                       : {{(data_w-imm_w){inst.imm[imm_w-1]}}, inst.imm};

    assign src2  = inst.src2_is_imm ? imm_ext : inst.rt_value;
    assign shamt = src1[4:0];

    assign sum  = src1 + src2;
    assign diff = src1 - src2;

    always_comb begin
        case (ctrl.alu_op)
            alu_add:  alu_result = sum;
            alu_sub:  alu_result = diff;
            alu_slt:  alu_result = {{(data_w-1){1'b0}}, $signed(src1) < $signed(src2)};
            alu_sltu: alu_result = {{(data_w-1){1'b0}}, src1 < src2};
            alu_and:  alu_result = src1 & src2;
            alu_or:   alu_result = src1 | src2;
            alu_xor:  alu_result = src1 ^ src2;
            alu_nor:  alu_result = ~(src1 | src2);
            alu_sll:  alu_result = src2 << shamt;
            alu_srl:  alu_result = src2 >> shamt;
            alu_sra:  alu_result = $signed(src2) >>> shamt;
            alu_lui:  alu_result = {src2[imm_w-1:0], {(data_w-imm_w){1'b0}}};
            default:  alu_result = sum;
        endcase
    end

    // signed overflow: result sign disagrees with what the operands imply
    assign add_ov = (src1[data_w-1] == src2[data_w-1]) &&
                    (sum[data_w-1] != src1[data_w-1]);
    assign sub_ov = (src1[data_w-1] != src2[data_w-1]) &&
                    (diff[data_w-1] != src1[data_w-1]);

    assign overflow = ctrl.check_ov && ((ctrl.alu_op == alu_sub) ? sub_ov : add_ov);

endmodule

/* hdl/exe_mem_access.sv */
module exe_mem_access import exe_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              es_valid,
    input  logic              accept,
    input  logic              ms_allowin,
    input  mem_op_e           mem_op,
    input  logic [data_w-1:0] addr,
    input  logic [data_w-1:0] rt_value,
    input  logic              overflow,
    input  logic              addr_ok,
    output mem_req_t          data_req,
    output logic              ready_go,
    output logic              addr_err_load,
    output logic              addr_err_store
);

    logic       is_load;
    logic       is_store;
    logic [1:0] size;
    logic       misaligned;
    logic       need_mem;
    logic       accepted;

    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        size     = size_word;
        case (mem_op)
            mem_lw:  is_load = 1'b1;
            mem_lh,
            mem_lhu: begin
                is_load = 1'b1;
                size    = size_half;
            end
            mem_lb,
            mem_lbu: begin
                is_load = 1'b1;
                size    = size_byte;
            end
            mem_sw:  is_store = 1'b1;
            mem_sh: begin
                is_store = 1'b1;
                size     = size_half;
            end
            mem_sb: begin
                is_store = 1'b1;
                size     = size_byte;
            end
            default: size = size_word;
        endcase
    end

    assign misaligned = (size == size_half && addr[0]) ||
                        (size == size_word && addr[1:0] != 2'b00);

    assign addr_err_load  = is_load && misaligned;
    assign addr_err_store = is_store && misaligned;

    // faulting instructions never touch memory
    assign need_mem = es_valid && (is_load || is_store) && !misaligned && !overflow;

    // request taken but the stage is still held by the memory stage
    always_ff @(posedge clk) begin
        if (reset) begin
            accepted <= 1'b0;
        end else if (accept) begin
            accepted <= 1'b0;
        end else if (data_req.en && addr_ok && !ms_allowin) begin
            accepted <= 1'b1;
        end
    end

    assign data_req.en   = need_mem && !accepted;
    assign data_req.wr   = is_store;
    assign data_req.size = size;
    assign data_req.addr = addr;

    always_comb begin
        data_req.wstrb = 4'b0000;
        if (is_store) begin
            case (size)
                size_byte: data_req.wstrb = 4'b0001 << addr[1:0];
                size_half: data_req.wstrb = addr[1] ? 4'b1100 : 4'b0011;
                default:   data_req.wstrb = 4'b1111;
            endcase
        end
    end

    always_comb begin
        case (size)
            size_byte: data_req.wdata = {4{rt_value[7:0]}};
            size_half: data_req.wdata = {2{rt_value[15:0]}};
            default:   data_req.wdata = rt_value;
        endcase
    end

    assign ready_go = !need_mem || accepted || addr_ok;

endmodule

/* hdl/exe_hilo.sv */
module exe_hilo import exe_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              commit,
    input  hilo_op_e          hilo_op,
    input  exc_code_e         exc_code,
    input  logic [data_w-1:0] rs_value,
    input  logic [data_w-1:0] rt_value,
    output logic [data_w-1:0] hi,
    output logic [data_w-1:0] lo
);

    logic signed [2*data_w-1:0] prod_s;
    logic        [2*data_w-1:0] prod_u;

    assign prod_s = $signed(rs_value) * $signed(rt_value);
    assign prod_u = rs_value * rt_value;

    // update only when the instruction leaves cleanly
    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (commit && exc_code == exc_none) begin
            case (hilo_op)
                hilo_mult: begin
                    hi <= prod_s[2*data_w-1:data_w];
                    lo <= prod_s[data_w-1:0];
                end
                hilo_multu: begin
                    hi <= prod_u[2*data_w-1:data_w];
                    lo <= prod_u[data_w-1:0];
                end
                hilo_mthi: hi <= rs_value;
                hilo_mtlo: lo <= rs_value;
                default: begin
                    hi <= hi;
                    lo <= lo;
                end
            endcase
        end
    end

endmodule

/* hdl/exe_result.sv */
module exe_result import exe_pkg::*; (
    input  ds_to_es_t         inst,
    input  exe_ctrl_t         ctrl,
    input  logic [data_w-1:0] alu_result,
    input  logic [data_w-1:0] hi,
    input  logic [data_w-1:0] lo,
    input  logic              overflow,
    input  logic              addr_err_load,
    input  logic              addr_err_store,
    output exc_code_e         exc_code,
    output es_to_ms_t         es_to_ms
);

    logic [data_w-1:0] result;
    logic              is_load;

    always_comb begin
        case (ctrl.res_sel)
            res_hi:  result = hi;
            res_lo:  result = lo;
            default: result = alu_result;
        endcase
    end

    // overflow first, then load, then store
    assign exc_code = overflow       ? exc_ov   :
                      addr_err_load  ? exc_adel :
                      addr_err_store ? exc_ades :
                                       exc_none;

    assign is_load = ctrl.mem_op inside {mem_lw, mem_lh, mem_lhu, mem_lb, mem_lbu};

    assign es_to_ms.pc       = inst.pc;
    assign es_to_ms.result   = result;
    assign es_to_ms.dest     = ctrl.dest;
    assign es_to_ms.gr_we    = ctrl.gr_we && (exc_code == exc_none);
    assign es_to_ms.is_load  = is_load;
    assign es_to_ms.exc_code = exc_code;
    // alu_result carries the effective address for memory ops
    assign es_to_ms.badvaddr = (addr_err_load || addr_err_store) ? alu_result : '0;

endmodule

/* hdl/exe_stage.sv */
module exe_stage import exe_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      ds_to_es_valid,
    input  ds_to_es_t ds_to_es,
    output logic      es_allowin,
    input  logic      ms_allowin,
    output logic      es_to_ms_valid,
    output es_to_ms_t es_to_ms,
    output mem_req_t  data_req,
    input  logic      addr_ok
);

    logic              es_valid;
    logic              ready_go;
    logic              accept;
    logic              commit;
    ds_to_es_t         inst;
    exe_ctrl_t         ctrl;
    logic [data_w-1:0] alu_result;
    logic              overflow;
    logic              addr_err_load;
    logic              addr_err_store;
    logic [data_w-1:0] hi;
    logic [data_w-1:0] lo;
    exc_code_e         exc_code;

    assign accept         = ds_to_es_valid && es_allowin;
    assign es_to_ms_valid = es_valid && ready_go;
    assign commit         = es_to_ms_valid && ms_allowin;

    exe_decode u_decode (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (ds_to_es_valid),
        .in_inst    (ds_to_es),
        .ms_allowin (ms_allowin),
        .ready_go   (ready_go),
        .es_valid   (es_valid),
        .es_allowin (es_allowin),
        .inst       (inst),
        .ctrl       (ctrl)
    );

    exe_alu u_alu (
        .inst       (inst),
        .ctrl       (ctrl),
        .alu_result (alu_result),
        .overflow   (overflow)
    );

    exe_mem_access u_mem_access (
        .clk            (clk),
        .reset          (reset),
        .es_valid       (es_valid),
        .accept         (accept),
        .ms_allowin     (ms_allowin),
        .mem_op         (ctrl.mem_op),
        .addr           (alu_result),
        .rt_value       (inst.rt_value),
        .overflow       (overflow),
        .addr_ok        (addr_ok),
        .data_req       (data_req),
        .ready_go       (ready_go),
        .addr_err_load  (addr_err_load),
        .addr_err_store (addr_err_store)
    );

    exe_hilo u_hilo (
        .clk      (clk),
        .reset    (reset),
        .commit   (commit),
        .hilo_op  (ctrl.hilo_op),
        .exc_code (exc_code),
        .rs_value (inst.rs_value),
        .rt_value (inst.rt_value),
        .hi       (hi),
        .lo       (lo)
    );

    exe_result u_result (
        .inst           (inst),
        .ctrl           (ctrl),
        .alu_result     (alu_result),
        .hi             (hi),
        .lo             (lo),
        .overflow       (overflow),
        .addr_err_load  (addr_err_load),
        .addr_err_store (addr_err_store),
        .exc_code       (exc_code),
        .es_to_ms       (es_to_ms)
    );

endmodule

/* tb/exe_stage_properties.sv */
module exe_stage_properties import exe_pkg::*; (
    input logic      clk,
    input logic      reset,
    input logic      es_to_ms_valid,
    input logic      ms_allowin,
    input es_to_ms_t es_to_ms,
    input mem_req_t  data_req,
    input logic      addr_ok
);

    // stage comes up empty
    a_quiet_after_reset: assert property (@(posedge clk)
        reset |=> !es_to_ms_valid && !data_req.en)
        else $error("output valid or memory request high right after reset");

    a_en_until_addr_ok: assert property (@(posedge clk) disable iff (reset)
        data_req.en && !addr_ok |=> data_req.en)
        else $error("memory request withdrawn before addr_ok");

    a_hold_under_stall: assert property (@(posedge clk) disable iff (reset)
        es_to_ms_valid && !ms_allowin |=> es_to_ms_valid && $stable(es_to_ms))
        else $error("bundle to the memory stage changed while stalled");

    a_no_strobe_on_read: assert property (@(posedge clk) disable iff (reset)
        !data_req.wr |-> data_req.wstrb == 4'b0000)
        else $error("byte enables set on a read request");

endmodule

bind exe_stage exe_stage_properties u_properties (
    .clk            (clk),
    .reset          (reset),
    .es_to_ms_valid (es_to_ms_valid),
    .ms_allowin     (ms_allowin),
    .es_to_ms       (es_to_ms),
    .data_req       (data_req),
    .addr_ok        (addr_ok)
);

/* tb/tb_exe_stage.sv */
module tb_exe_stage import exe_pkg::*; ();

    logic        clk;
    logic        reset;
    logic        ds_to_es_valid;
    ds_to_es_t   ds_to_es;
    logic        es_allowin;
    logic        ms_allowin;
    logic        es_to_ms_valid;
    es_to_ms_t   es_to_ms;
    mem_req_t    data_req;
    logic        addr_ok;

    logic [31:0] lcg_state;
    logic [31:0] model_hi;
    logic [31:0] model_lo;
    es_to_ms_t   out_snap;
    mem_req_t    req_snap;
    int          errors;
    int          tests;
    int          wait_limit = 50;

    exe_stage dut (
        .clk            (clk),
        .reset          (reset),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es       (ds_to_es),
        .es_allowin     (es_allowin),
        .ms_allowin     (ms_allowin),
        .es_to_ms_valid (es_to_ms_valid),
        .es_to_ms       (es_to_ms),
        .data_req       (data_req),
        .addr_ok        (addr_ok)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function ds_to_es_t make_inst(exe_op_e op, mem_op_e mop, logic use_imm, logic zext,
                                  logic [15:0] imm, logic [31:0] rs, logic [31:0] rt);
        ds_to_es_t d;
        logic [31:0] r;
        r = lcg_next();
        d.op           = op;
        d.mem_op       = mop;
        d.src1_is_sa   = op inside {op_sll, op_srl, op_sra};
        d.src2_is_imm  = use_imm;
        d.imm_zero_ext = zext;
        d.gr_we        = !(op inside {op_mult, op_multu, op_mthi, op_mtlo}) &&
                         !(mop inside {mem_sw, mem_sh, mem_sb});
        d.dest         = r[4:0];
        d.imm          = imm;
        d.rs_value     = rs;
        d.rt_value     = rt;
        d.pc           = {r[31:2], 2'b00};
        return d;
    endfunction

    // reference ALU and effective address of memory ops
    function logic [31:0] exp_alu(ds_to_es_t d);
        logic [31:0] a;
        logic [31:0] b;
        a = d.rs_value;
        if (!d.src2_is_imm)
            b = d.rt_value;
        else if (d.imm_zero_ext)
            b = {16'h0000, d.imm};
        else
            b = {{16{d.imm[15]}}, d.imm};
        case (d.op)
            op_sub, op_subu: return a - b;
            op_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            op_sltu: return (a < b) ? 32'd1 : 32'd0;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_nor:  return ~(a | b);
            op_sll:  return d.rt_value << d.imm[10:6];
            op_srl:  return d.rt_value >> d.imm[10:6];
            op_sra:  return $signed(d.rt_value) >>> d.imm[10:6];
            op_lui:  return {d.imm, 16'h0000};
            default: return a + b;
        endcase
    endfunction

    // overflow when the top two bits of the 33-bit signed sum differ
    function logic exp_ov(ds_to_es_t d);
        logic [32:0] s;
        logic [31:0] b;
        b = d.src2_is_imm ? {{16{d.imm[15]}}, d.imm} : d.rt_value;
        s = 33'd0;
        if (d.op == op_add)
            s = {d.rs_value[31], d.rs_value} + {b[31], b};
        else if (d.op == op_sub)
            s = {d.rs_value[31], d.rs_value} - {b[31], b};
        return s[32] != s[31];
    endfunction

    task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic note_problem(string msg);
        $display("ERROR at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic issue_inst(ds_to_es_t d);
        int n;
        @(negedge clk);
        ds_to_es_valid = 1'b1;
        ds_to_es       = d;
        #1;
        n = 0;
        while (!es_allowin && n < wait_limit) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (!es_allowin)
            note_problem("stage never accepted the instruction from decode");
        @(negedge clk);
        ds_to_es_valid = 1'b0;
    endtask

    task automatic wait_output();
        int n;
        #1;
        n = 0;
        while (!es_to_ms_valid && n < wait_limit) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (!es_to_ms_valid)
            note_problem("no result reached the memory stage in time");
        out_snap = es_to_ms;
        req_snap = data_req;
    endtask

    task automatic run_check(ds_to_es_t d, logic [31:0] exp_res, exc_code_e exp_exc,
                             logic chk_res);
        logic [31:0] bad;
        issue_inst(d);
        wait_output();
        bad = (exp_exc == exc_adel || exp_exc == exc_ades) ? exp_res : 32'h0;
        if (chk_res)
            check_val("result", out_snap.result, exp_res);
        check_val("exc_code", out_snap.exc_code, exp_exc);
        check_val("dest", out_snap.dest, d.dest);
        check_val("gr_we", out_snap.gr_we, d.gr_we && exp_exc == exc_none);
        check_val("pc", out_snap.pc, d.pc);
        check_val("badvaddr", out_snap.badvaddr, bad);
        check_val("is_load", out_snap.is_load,
                  d.mem_op inside {mem_lw, mem_lh, mem_lhu, mem_lb, mem_lbu});
    endtask

    task automatic finish_test(string name, int e0);
        tests++;
        $display("%s: %0d errors", name, errors - e0);
    endtask

    task automatic read_hilo();
        run_check(make_inst(op_mfhi, mem_none, 1'b0, 1'b0, 16'h0, 32'h0, 32'h0),
                  model_hi, exc_none, 1'b1);
        run_check(make_inst(op_mflo, mem_none, 1'b0, 1'b0, 16'h0, 32'h0, 32'h0),
                  model_lo, exc_none, 1'b1);
    endtask

    task automatic test_alu();
        int e0;
        exe_op_e op;
        ds_to_es_t d;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic use_imm;
        e0 = errors;
        for (int i = 0; i < 4; i++) begin
            for (int k = 0; k <= 13; k++) begin
                op = exe_op_e'(k);
                a = lcg_next();
                b = lcg_next();
                r = lcg_next();
                // keep add and sub away from overflow here
                if (op inside {op_add, op_sub}) begin
                    a = {{3{a[31]}}, a[31:3]};
                    b = {{3{b[31]}}, b[31:3]};
                    r[15] = r[14];
                end
                use_imm = (i[0] && op inside {op_add, op_addu, op_slt, op_sltu, op_and,
                                              op_or, op_xor}) || op == op_lui;
                d = make_inst(op, mem_none, use_imm, op inside {op_and, op_or, op_xor},
                              r[15:0], a, b);
                run_check(d, exp_alu(d), exp_ov(d) ? exc_ov : exc_none, 1'b1);
            end
        end
        finish_test("alu operations", e0);
    endtask

    task automatic test_overflow();
        int e0;
        e0 = errors;
        run_check(make_inst(op_add, mem_none, 1'b0, 1'b0, 16'h0, 32'h7fff_ffff, 32'h1),
                  32'h0, exc_ov, 1'b0);
        run_check(make_inst(op_addu, mem_none, 1'b0, 1'b0, 16'h0, 32'h7fff_ffff, 32'h1),
                  32'h8000_0000, exc_none, 1'b1);
        run_check(make_inst(op_sub, mem_none, 1'b0, 1'b0, 16'h0, 32'h8000_0000, 32'h1),
                  32'h0, exc_ov, 1'b0);
        run_check(make_inst(op_subu, mem_none, 1'b0, 1'b0, 16'h0, 32'h8000_0000, 32'h1),
                  32'h7fff_ffff, exc_none, 1'b1);
        run_check(make_inst(op_add, mem_none, 1'b1, 1'b0, 16'h0010, 32'h7fff_fff0, 32'h0),
                  32'h0, exc_ov, 1'b0);
        finish_test("overflow trap", e0);
    endtask

    task automatic test_hilo();
        int e0;
        logic [31:0] a;
        logic [31:0] b;
        logic [63:0] p;
        exe_op_e op;
        e0 = errors;
        read_hilo();
        for (int i = 0; i < 5; i++) begin
            a = lcg_next();
            b = lcg_next();
            op = i[0] ? op_multu : op_mult;
            // a faulting add right before the last multiply
            if (i == 4)
                run_check(make_inst(op_add, mem_none, 1'b0, 1'b0, 16'h0, 32'h7fff_ffff,
                                    32'h7fff_ffff), 32'h0, exc_ov, 1'b0);
            run_check(make_inst(op, mem_none, 1'b0, 1'b0, 16'h0, a, b), 32'h0, exc_none, 1'b0);
            if (op == op_mult)
                p = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
            else
                p = {32'h0, a} * {32'h0, b};
            model_hi = p[63:32];
            model_lo = p[31:0];
            read_hilo();
        end
        a = lcg_next();
        b = lcg_next();
        run_check(make_inst(op_mthi, mem_none, 1'b0, 1'b0, 16'h0, a, b), 32'h0, exc_none, 1'b0);
        run_check(make_inst(op_mtlo, mem_none, 1'b0, 1'b0, 16'h0, b, a), 32'h0, exc_none, 1'b0);
        model_hi = a;
        model_lo = b;
        read_hilo();
        finish_test("hi/lo", e0);
    endtask

    task automatic mem_case(mem_op_e mop, logic [15:0] off, logic wr, logic [1:0] size,
                            logic [3:0] wstrb, logic [31:0] rt);
        ds_to_es_t d;
        logic [31:0] base;
        base = lcg_next() & 32'h0fff_fff0;
        d = make_inst(op_addu, mop, 1'b1, 1'b0, off, base, rt);
        run_check(d, 32'h0, exc_none, 1'b0);
        check_val("data_req.en", req_snap.en, 1'b1);
        check_val("data_req.wr", req_snap.wr, wr);
        check_val("data_req.size", req_snap.size, size);
        check_val("data_req.addr", req_snap.addr, exp_alu(d));
        check_val("data_req.wstrb", req_snap.wstrb, wstrb);
    endtask

    task automatic test_mem();
        int e0;
        logic [31:0] rt;
        ds_to_es_t d;
        e0 = errors;
        for (int k = 0; k < 4; k++) begin
            rt = lcg_next();
            mem_case(mem_sb, k, 1'b1, 2'd0, 4'b0001 << k, rt);
            check_val("data_req.wdata", req_snap.wdata, {4{rt[7:0]}});
        end
        for (int k = 0; k < 4; k += 2) begin
            rt = lcg_next();
            mem_case(mem_sh, k, 1'b1, 2'd1, (k == 2) ? 4'b1100 : 4'b0011, rt);
            check_val("data_req.wdata", req_snap.wdata, {2{rt[15:0]}});
        end
        rt = lcg_next();
        mem_case(mem_sw, 16'hfffc, 1'b1, 2'd2, 4'b1111, rt);
        check_val("data_req.wdata", req_snap.wdata, rt);
        mem_case(mem_lw, 16'h0008, 1'b0, 2'd2, 4'b0000, lcg_next());
        mem_case(mem_lh, 16'h0002, 1'b0, 2'd1, 4'b0000, lcg_next());
        mem_case(mem_lhu, 16'h0006, 1'b0, 2'd1, 4'b0000, lcg_next());
        mem_case(mem_lb, 16'h0003, 1'b0, 2'd0, 4'b0000, lcg_next());
        mem_case(mem_lbu, 16'h0001, 1'b0, 2'd0, 4'b0000, lcg_next());
        // memory slow to take the request
        @(negedge clk);
        addr_ok = 1'b0;
        d = make_inst(op_addu, mem_sw, 1'b1, 1'b0, 16'h4, lcg_next() & 32'hffff_fff0, 32'h0);
        issue_inst(d);
        for (int c = 0; c < 4; c++) begin
            #1;
            if (data_req.en !== 1'b1)
                note_problem("memory request dropped before addr_ok");
            if (es_to_ms_valid !== 1'b0)
                note_problem("store passed on before its request was taken");
            @(negedge clk);
        end
        addr_ok = 1'b1;
        wait_output();
        check_val("data_req.en", req_snap.en, 1'b1);
        check_val("data_req.addr", req_snap.addr, exp_alu(d));
        finish_test("loads and stores", e0);
    endtask

    task automatic addr_err_case(mem_op_e mop, logic [15:0] off, exc_code_e exc);
        ds_to_es_t d;
        d = make_inst(op_addu, mop, 1'b1, 1'b0, off, lcg_next() & 32'h0fff_fff0, lcg_next());
        run_check(d, exp_alu(d), exc, 1'b0);
        check_val("data_req.en", req_snap.en, 1'b0);
    endtask

    task automatic test_addr_err();
        int e0;
        e0 = errors;
        addr_err_case(mem_lw, 16'h0002, exc_adel);
        addr_err_case(mem_lh, 16'h0001, exc_adel);
        addr_err_case(mem_lhu, 16'h0003, exc_adel);
        addr_err_case(mem_sw, 16'h0001, exc_ades);
        addr_err_case(mem_sh, 16'h0003, exc_ades);
        finish_test("address errors", e0);
    endtask

    task automatic test_backpressure();
        int e0;
        logic [31:0] a;
        es_to_ms_t held;
        ds_to_es_t d2;
        e0 = errors;
        @(negedge clk);
        ms_allowin = 1'b0;
        a = lcg_next();
        run_check(make_inst(op_mthi, mem_none, 1'b0, 1'b0, 16'h0, a, 32'h0),
                  32'h0, exc_none, 1'b0);
        held = out_snap;
        d2 = make_inst(op_mfhi, mem_none, 1'b0, 1'b0, 16'h0, 32'h0, 32'h0);
        for (int c = 0; c < 3; c++) begin
            @(negedge clk);
            ds_to_es_valid = 1'b1;
            ds_to_es       = d2;
            #1;
            if (es_allowin !== 1'b0)
                note_problem("es_allowin high while the memory stage is stalled");
            if (es_to_ms !== held || es_to_ms_valid !== 1'b1)
                note_problem("output bundle changed under back-pressure");
        end
        @(negedge clk);
        ds_to_es_valid = 1'b0;
        ms_allowin     = 1'b1;
        model_hi = a;
        run_check(d2, model_hi, exc_none, 1'b1);
        run_check(make_inst(op_mflo, mem_none, 1'b0, 1'b0, 16'h0, 32'h0, 32'h0),
                  model_lo, exc_none, 1'b1);
        // store taken by memory while the stage is held
        @(negedge clk);
        ms_allowin = 1'b0;
        d2 = make_inst(op_addu, mem_sw, 1'b1, 1'b0, 16'h8, lcg_next() & 32'h0fff_fff0, a);
        run_check(d2, 32'h0, exc_none, 1'b0);
        check_val("data_req.en", req_snap.en, 1'b1);
        for (int c = 0; c < 2; c++) begin
            @(negedge clk);
            #1;
            if (data_req.en !== 1'b0)
                note_problem("memory request issued again under back-pressure");
            if (es_to_ms_valid !== 1'b1)
                note_problem("store lost its valid under back-pressure");
        end
        @(negedge clk);
        ms_allowin = 1'b1;
        finish_test("back-pressure", e0);
    endtask

    initial begin
        lcg_state      = 32'h5c74;
        errors         = 0;
        tests          = 0;
        model_hi       = 32'h0;
        model_lo       = 32'h0;
        reset          = 1'b1;
        ds_to_es_valid = 1'b0;
        ds_to_es       = '0;
        ms_allowin     = 1'b1;
        addr_ok        = 1'b1;
        repeat (3) @(negedge clk);
        reset = 1'b0;

        test_hilo();
        test_alu();
        test_overflow();
        test_mem();
        test_addr_err();
        test_backpressure();

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
hdl/exe_pkg.sv
hdl/exe_decode.sv
hdl/exe_alu.sv
hdl/exe_mem_access.sv
hdl/exe_hilo.sv
hdl/exe_result.sv
hdl/exe_stage.sv
tb/exe_stage_properties.sv
tb/tb_exe_stage.sv
